// ==== ex_settings.svh ====
// execute unit settings: data path, register number, opcode and divide step widths
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// width of one data word, operand, result, HI or LO
`define EX_DATA_W 32

// destination register number width
`define EX_REG_ADDR_W 5

// operation code width, room for all execute ops
`define EX_OP_W 5

// one quotient bit per divider iteration
`define EX_DIV_STEPS 32

`endif

// ==== ex_pkg.sv ====
// execute unit package with data types, op and divider state enums and stage result structs
`include "ex_settings.svh"

package ex_pkg;

        typedef logic [`EX_DATA_W-1:0] data_t;

        typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

        // remainder in the upper half, quotient in the lower half
        typedef logic [2*`EX_DATA_W-1:0] dword_t;

        typedef enum logic [`EX_OP_W-1:0]
        {
                OP_NOP,
                OP_AND,
                OP_OR,
                OP_XOR,
                OP_NOR,
                OP_SLL,
                OP_SRL,
                OP_SRA,
                OP_ADDU,
                OP_SUBU,
                OP_SLT,
                OP_SLTU,
                OP_MFHI,
                OP_MFLO,
                OP_MTHI,
                OP_MTLO,
                OP_DIV,
                OP_DIVU
        } ex_op_e;

        typedef enum logic [1:0]
        {
                DIV_IDLE,
                DIV_ZERO,
                DIV_RUN,
                DIV_END
        } div_state_e;

        // alu stage to writeback
        typedef struct packed
        {
                logic      valid;
                ex_op_e    op;
                reg_addr_t wd;
                data_t     data;
        } alu_out_t;

        // divider to writeback, rem goes to HI and quot to LO
        typedef struct packed
        {
                logic  done;
                data_t rem;
                data_t quot;
        } div_out_t;

endpackage

// ==== alu_stage.sv ====
// ALU stage computing logic, shift, add, subtract and compare results into a pipeline register
`timescale 1ns/1ps

module alu_stage
(
        input  logic              clk,
        input  logic              reset_i,
        input  logic              issue_i,
        input  ex_pkg::ex_op_e    op_i,
        input  ex_pkg::data_t     opnd_a_i,
        input  ex_pkg::data_t     opnd_b_i,
        input  ex_pkg::reg_addr_t wd_i,
        output ex_pkg::alu_out_t  alu_o
);

        import ex_pkg::*;

        data_t      result;
        logic [4:0] shamt;
        logic       item_valid;

        // shift amount from the low five bits of operand b
        assign shamt = opnd_b_i[4:0];

        // divides are carried by the divider only
        assign item_valid = issue_i && (op_i != OP_NOP) && (op_i != OP_DIV) &&
                            (op_i != OP_DIVU);

        always_comb
        begin
                case (op_i)
                        OP_AND:
                                result = opnd_a_i & opnd_b_i;
                        OP_OR:
                                result = opnd_a_i | opnd_b_i;
                        OP_XOR:
                                result = opnd_a_i ^ opnd_b_i;
                        OP_NOR:
                                result = ~(opnd_a_i | opnd_b_i);
                        OP_SLL:
                                result = opnd_a_i << shamt;
                        OP_SRL:
                                result = opnd_a_i >> shamt;
                        OP_SRA:
                                result = data_t'($signed(opnd_a_i) >>> shamt);
                        OP_ADDU:
                                result = opnd_a_i + opnd_b_i;
                        OP_SUBU:
                                result = opnd_a_i - opnd_b_i;
                        OP_SLT:
                                result = data_t'($signed(opnd_a_i) < $signed(opnd_b_i));
                        OP_SLTU:
                                result = data_t'(opnd_a_i < opnd_b_i);
                        // value to be moved into HI or LO
                        OP_MTHI,
                        OP_MTLO:
                                result = opnd_a_i;
                        // MFHI and MFLO get their data in writeback
                        default:
                                result = '0;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (reset_i)
                begin
                        alu_o.valid <= 1'b0;
                end
                else
                begin
                        alu_o.valid <= item_valid;
                end
                alu_o.op   <= op_i;
                alu_o.wd   <= wd_i;
                alu_o.data <= result;
        end

endmodule

// ==== div_unit.sv ====
// iterative radix-2 divider for signed and unsigned 32-bit division with busy level and done pulse
`timescale 1ns/1ps
`include "ex_settings.svh"

module div_unit
(
        input  logic              clk,
        input  logic              reset_i,
        input  logic              issue_i,
        input  ex_pkg::ex_op_e    op_i,
        input  ex_pkg::data_t     dividend_i,
        input  ex_pkg::data_t     divisor_i,
        output logic              busy_o,
        output ex_pkg::div_out_t  div_o
);

        import ex_pkg::*;

        localparam int CNT_W = $clog2(`EX_DIV_STEPS) + 1;

        div_state_e         state_q;
        logic [CNT_W-1:0]   count_q;
        dword_t             work_q;
        dword_t             work_next;
        data_t              divisor_q;
        logic               quot_neg_q;
        logic               rem_neg_q;
        logic               start;
        logic               a_neg;
        logic               b_neg;
        data_t              abs_a;
        data_t              abs_b;
        logic [`EX_DATA_W:0] partial;
        logic [`EX_DATA_W:0] diff;

        assign start = issue_i && ((op_i == OP_DIV) || (op_i == OP_DIVU));

        // operand signs only count for the signed divide
        assign a_neg = (op_i == OP_DIV) && dividend_i[`EX_DATA_W-1];
        assign b_neg = (op_i == OP_DIV) && divisor_i[`EX_DATA_W-1];
        assign abs_a = a_neg ? -dividend_i : dividend_i;
        assign abs_b = b_neg ? -divisor_i : divisor_i;

        // shift left one bit, subtract the divisor if it fits
        assign partial = work_q[2*`EX_DATA_W-1:`EX_DATA_W-1];
        assign diff    = partial - {1'b0, divisor_q};

        always_comb
        begin
                if (!diff[`EX_DATA_W])
                begin
                        work_next = {diff[`EX_DATA_W-1:0], work_q[`EX_DATA_W-2:0], 1'b1};
                end
                else
                begin
                        work_next = {partial[`EX_DATA_W-1:0], work_q[`EX_DATA_W-2:0], 1'b0};
                end
        end

        always_ff @(posedge clk)
        begin
                if (reset_i)
                begin
                        state_q <= DIV_IDLE;
                        count_q <= '0;
                end
                else
                begin
                        case (state_q)
                                DIV_IDLE:
                                begin
                                        count_q <= '0;
                                        if (start)
                                        begin
                                                state_q <= (divisor_i == '0) ? DIV_ZERO : DIV_RUN;
                                        end
                                end
                                DIV_ZERO:
                                        state_q <= DIV_END;
                                DIV_RUN:
                                begin
                                        count_q <= count_q + 1'b1;
                                        if (count_q == CNT_W'(`EX_DIV_STEPS - 1))
                                        begin
                                                state_q <= DIV_END;
                                        end
                                end
                                default:
                                        state_q <= DIV_IDLE;
                        endcase
                end
        end

        // working register, divisor and sign flags
        always_ff @(posedge clk)
        begin
                case (state_q)
                        DIV_IDLE:
                        begin
                                if (start)
                                begin
                                        work_q     <= dword_t'(abs_a);
                                        divisor_q  <= abs_b;
                                        quot_neg_q <= a_neg ^ b_neg;
                                        rem_neg_q  <= a_neg;
                                end
                        end
                        DIV_ZERO:
                                work_q <= '0;
                        DIV_RUN:
                                work_q <= work_next;
                        default:
                                work_q <= work_q;
                endcase
        end

        assign busy_o = (state_q != DIV_IDLE);

        // sign correction, remainder follows the dividend
        assign div_o.done = (state_q == DIV_END);
        assign div_o.rem  = rem_neg_q ? -work_q[2*`EX_DATA_W-1:`EX_DATA_W] :
                                        work_q[2*`EX_DATA_W-1:`EX_DATA_W];
        assign div_o.quot = quot_neg_q ? -work_q[`EX_DATA_W-1:0] : work_q[`EX_DATA_W-1:0];

endmodule

// ==== hilo_writeback.sv ====
// writeback stage holding HI and LO, merging ALU and divider results into the register write pulse
`timescale 1ns/1ps

module hilo_writeback
(
        input  logic              clk,
        input  logic              reset_i,
        input  ex_pkg::alu_out_t  alu_i,
        input  ex_pkg::div_out_t  div_i,
        output logic              result_valid_o,
        output ex_pkg::reg_addr_t result_wd_o,
        output ex_pkg::data_t     result_data_o,
        output ex_pkg::data_t     hi_o,
        output ex_pkg::data_t     lo_o
);

        import ex_pkg::*;

        data_t hi_q;
        data_t lo_q;
        data_t wb_data;
        logic  writes_reg;

        // moves into HI/LO write no register
        assign writes_reg = alu_i.valid && (alu_i.op != OP_MTHI) && (alu_i.op != OP_MTLO);

        // move-from reads the registers here, so a move-to just ahead is seen
        always_comb
        begin
                case (alu_i.op)
                        OP_MFHI:
                                wb_data = hi_q;
                        OP_MFLO:
                                wb_data = lo_q;
                        default:
                                wb_data = alu_i.data;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (reset_i)
                begin
                        hi_q <= '0;
                        lo_q <= '0;
                end
                else if (div_i.done)
                begin
                        hi_q <= div_i.rem;
                        lo_q <= div_i.quot;
                end
                else if (alu_i.valid && (alu_i.op == OP_MTHI))
                begin
                        hi_q <= alu_i.data;
                end
                else if (alu_i.valid && (alu_i.op == OP_MTLO))
                begin
                        lo_q <= alu_i.data;
                end
        end

        always_ff @(posedge clk)
        begin
                if (reset_i)
                begin
                        result_valid_o <= 1'b0;
                end
                else
                begin
                        result_valid_o <= writes_reg;
                end
                result_wd_o   <= alu_i.wd;
                result_data_o <= wb_data;
        end

        assign hi_o = hi_q;
        assign lo_o = lo_q;

endmodule

// ==== ex_unit.sv ====
// execute unit top connecting the ALU stage, the divider and the HI/LO writeback stage
`timescale 1ns/1ps

module ex_unit
(
        input  logic              clk,
        input  logic              reset_i,
        input  logic              issue_i,
        input  ex_pkg::ex_op_e    op_i,
        input  ex_pkg::data_t     opnd_a_i,
        input  ex_pkg::data_t     opnd_b_i,
        input  ex_pkg::reg_addr_t wd_i,
        output logic              busy_o,
        output logic              result_valid_o,
        output ex_pkg::reg_addr_t result_wd_o,
        output ex_pkg::data_t     result_data_o,
        output ex_pkg::data_t     hi_o,
        output ex_pkg::data_t     lo_o
);

        import ex_pkg::*;

        alu_out_t alu_out;
        div_out_t div_out;

        // single-cycle ops, registered
        alu_stage alu_stage_inst
        (
                .clk      (clk),
                .reset_i  (reset_i),
                .issue_i  (issue_i),
                .op_i     (op_i),
                .opnd_a_i (opnd_a_i),
                .opnd_b_i (opnd_b_i),
                .wd_i     (wd_i),
                .alu_o    (alu_out)
        );

        // runs beside the ALU, busy holds off further issue
        div_unit div_unit_inst
        (
                .clk        (clk),
                .reset_i    (reset_i),
                .issue_i    (issue_i),
                .op_i       (op_i),
                .dividend_i (opnd_a_i),
                .divisor_i  (opnd_b_i),
                .busy_o     (busy_o),
                .div_o      (div_out)
        );

        hilo_writeback hilo_writeback_inst
        (
                .clk            (clk),
                .reset_i        (reset_i),
                .alu_i          (alu_out),
                .div_i          (div_out),
                .result_valid_o (result_valid_o),
                .result_wd_o    (result_wd_o),
                .result_data_o  (result_data_o),
                .hi_o           (hi_o),
                .lo_o           (lo_o)
        );

endmodule

// ==== ex_checker.sv ====
// testbench checker watching the execute unit ports and comparing results with expected values
`timescale 1ns/1ps

module ex_checker
(
        input  logic              clk,
        input  logic              reset_i,
        input  logic              issue_i,
        input  ex_pkg::ex_op_e    op_i,
        input  logic              busy_i,
        input  logic              result_valid_i,
        input  ex_pkg::reg_addr_t result_wd_i,
        input  ex_pkg::data_t     result_data_i,
        input  ex_pkg::data_t     hi_i,
        input  ex_pkg::data_t     lo_i
);

        import ex_pkg::*;

        localparam int RESULT_TIMEOUT = 20;

        typedef struct
        {
                string     name;
                reg_addr_t wd;
                data_t     data;
        } expect_t;

        expect_t    pending[$];
        expect_t    head;
        // register-writing issues seen one and two cycles ago
        logic [1:0] due = 2'b00;
        int         pass_count = 0;
        int         fail_count = 0;

        // ALU ops plus move-from write a register
        function automatic logic writes_register(input ex_op_e op);
                return op inside {OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
                                  OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU, OP_MFHI, OP_MFLO};
        endfunction

        task automatic push_expect(input string name, input reg_addr_t wd, input data_t data);
                expect_t e;
                e.name = name;
                e.wd   = wd;
                e.data = data;
                pending.push_back(e);
        endtask

        task automatic note_error(input string msg);
                $display("%s", msg);
                fail_count++;
        endtask

        // sampled on the falling edge, away from the DUT's updates
        always @(negedge clk)
        begin
                if (result_valid_i)
                begin
                        if (pending.size() == 0)
                        begin
                                $display("unexpected result for register %0d with data %h",
                                         result_wd_i, result_data_i);
                                fail_count++;
                        end
                        else
                        begin
                                head = pending.pop_front();
                                if (!due[1])
                                begin
                                        $display("%s: result did not come two cycles after issue",
                                                 head.name);
                                        fail_count++;
                                end
                                else if (result_wd_i !== head.wd || result_data_i !== head.data)
                                begin
                                        $display("Fail %s: expected wd %0d data %h, actual wd %0d data %h",
                                                 head.name, head.wd, head.data, result_wd_i,
                                                 result_data_i);
                                        fail_count++;
                                end
                                else
                                begin
                                        $display("pass %s", head.name);
                                        pass_count++;
                                end
                        end
                end
                else if (due[1] && pending.size() != 0)
                begin
                        head = pending.pop_front();
                        $display("%s: no result two cycles after issue", head.name);
                        fail_count++;
                end
                due = {due[0], issue_i && !reset_i && writes_register(op_i)};
        end

        task automatic wait_results();
                int cycles;
                cycles = 0;
                while (pending.size() != 0 && cycles < RESULT_TIMEOUT)
                begin
                        @(negedge clk);
                        cycles++;
                end
                if (pending.size() != 0)
                begin
                        $display("timeout: %0d results never arrived", pending.size());
                        fail_count += pending.size();
                        pending.delete();
                end
        endtask

        task automatic check_hilo(input string name, input data_t exp_hi, input data_t exp_lo);
                if (hi_i !== exp_hi || lo_i !== exp_lo)
                begin
                        $display("Fail %s: expected hi %h lo %h, actual hi %h lo %h",
                                 name, exp_hi, exp_lo, hi_i, lo_i);
                        fail_count++;
                end
                else
                begin
                        $display("pass %s", name);
                        pass_count++;
                end
        endtask

        task automatic check_busy(input string name, input logic exp);
                if (busy_i !== exp)
                begin
                        $display("Fail %s: expected busy %b, actual busy %b", name, exp, busy_i);
                        fail_count++;
                end
                else
                begin
                        $display("pass %s", name);
                        pass_count++;
                end
        endtask

endmodule

// ==== tb_ex_unit.sv ====
// testbench top for the execute unit, runs a table of ALU, HI/LO move and divide rows
`timescale 1ns/1ps

module tb_ex_unit;

        import ex_pkg::*;

        localparam int BUSY_TIMEOUT  = 100;
        localparam int RAND_ALU_ROWS = 24;
        localparam int RAND_DIV_ROWS = 6;

        // divide rows keep LO in exp and HI in exp_hi
        typedef struct
        {
                string     name;
                ex_op_e    op;
                data_t     a;
                data_t     b;
                reg_addr_t wd;
                data_t     exp;
                data_t     exp_hi;
        } row_t;

        logic        clk;
        logic        reset_i;
        logic        issue_i;
        ex_op_e      op_i;
        data_t       opnd_a_i;
        data_t       opnd_b_i;
        reg_addr_t   wd_i;
        logic        busy_o;
        logic        result_valid_o;
        reg_addr_t   result_wd_o;
        data_t       result_data_o;
        data_t       hi_o;
        data_t       lo_o;

        row_t        rows[$];
        logic [31:0] rand_state = 32'hbf76_7c1e;
        ex_op_e      alu_ops[11] = '{OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
                                     OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU};

        ex_unit ex_unit_inst
        (
                .clk            (clk),
                .reset_i        (reset_i),
                .issue_i        (issue_i),
                .op_i           (op_i),
                .opnd_a_i       (opnd_a_i),
                .opnd_b_i       (opnd_b_i),
                .wd_i           (wd_i),
                .busy_o         (busy_o),
                .result_valid_o (result_valid_o),
                .result_wd_o    (result_wd_o),
                .result_data_o  (result_data_o),
                .hi_o           (hi_o),
                .lo_o           (lo_o)
        );

        ex_checker checker_inst
        (
                .clk            (clk),
                .reset_i        (reset_i),
                .issue_i        (issue_i),
                .op_i           (op_i),
                .busy_i         (busy_o),
                .result_valid_i (result_valid_o),
                .result_wd_i    (result_wd_o),
                .result_data_i  (result_data_o),
                .hi_i           (hi_o),
                .lo_i           (lo_o)
        );

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        function automatic data_t next_rand();
                rand_state = rand_state * 32'd1664525 + 32'd1013904223;
                return rand_state;
        endfunction

        // register result by the arithmetic rules
        function automatic data_t expect_alu_result(input ex_op_e op, input data_t a,
                                                    input data_t b);
                data_t r;
                case (op)
                        OP_AND:  r = a & b;
                        OP_OR:   r = a | b;
                        OP_XOR:  r = a ^ b;
                        OP_NOR:  r = ~(a | b);
                        OP_SLL:  r = a << b[4:0];
                        OP_SRL:  r = a >> b[4:0];
                        // vacated top bits take the sign of a
                        OP_SRA:
                        begin
                                r = a >> b[4:0];
                                if (a[31])
                                        r = r | ~(32'hffff_ffff >> b[4:0]);
                        end
                        OP_ADDU: r = a + b;
                        OP_SUBU: r = a - b;
                        // differing signs decide alone, else an unsigned compare
                        OP_SLT:  r = (a[31] != b[31]) ? {31'd0, a[31]} :
                                     ((a < b) ? 32'd1 : 32'd0);
                        OP_SLTU: r = (a < b) ? 32'd1 : 32'd0;
                        default: r = '0;
                endcase
                return r;
        endfunction

        // truncating divide, remainder keeps the dividend sign
        function automatic void expect_div_result(input ex_op_e op, input data_t a,
                                                  input data_t b, output data_t hi,
                                                  output data_t lo);
                logic  neg_a;
                logic  neg_b;
                data_t ua;
                data_t ub;
                neg_a = (op == OP_DIV) && a[31];
                neg_b = (op == OP_DIV) && b[31];
                ua = neg_a ? -a : a;
                ub = neg_b ? -b : b;
                if (b == '0)
                begin
                        hi = '0;
                        lo = '0;
                end
                else
                begin
                        lo = ua / ub;
                        hi = ua % ub;
                        if (neg_a ^ neg_b)
                                lo = -lo;
                        if (neg_a)
                                hi = -hi;
                end
        endfunction

        function automatic void add_row(input string name, input ex_op_e op, input data_t a,
                                        input data_t b, input reg_addr_t wd, input data_t exp,
                                        input data_t exp_hi);
                row_t r;
                r.name   = name;
                r.op     = op;
                r.a      = a;
                r.b      = b;
                r.wd     = wd;
                r.exp    = exp;
                r.exp_hi = exp_hi;
                rows.push_back(r);
        endfunction

        function automatic void build_table();
                ex_op_e op;
                data_t  a;
                data_t  b;
                data_t  s;
                data_t  hi;
                data_t  lo;
                // directed ALU rows, issued back to back
                add_row("and", OP_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 5'd1, 32'h00f0_1200, '0);
                add_row("or", OP_OR, 32'hf000_000f, 32'h0a00_00a0, 5'd2, 32'hfa00_00af, '0);
                add_row("xor", OP_XOR, 32'hffff_0000, 32'h0f0f_0f0f, 5'd3, 32'hf0f0_0f0f, '0);
                add_row("nor", OP_NOR, 32'h0000_ffff, 32'h00ff_0000, 5'd4, 32'hff00_0000, '0);
                add_row("sll_low5", OP_SLL, 32'h0000_0001, 32'h0000_0024, 5'd5, 32'h10, '0);
                add_row("srl", OP_SRL, 32'h8000_0000, 32'd31, 5'd6, 32'h1, '0);
                add_row("sra_neg", OP_SRA, 32'h8000_0000, 32'd4, 5'd7, 32'hf800_0000, '0);
                add_row("sra_pos", OP_SRA, 32'h7000_0000, 32'h21, 5'd8, 32'h3800_0000, '0);
                add_row("addu_wrap", OP_ADDU, 32'hffff_ffff, 32'd2, 5'd9, 32'h1, '0);
                add_row("subu_wrap", OP_SUBU, 32'd1, 32'd2, 5'd10, 32'hffff_ffff, '0);
                add_row("slt_neg", OP_SLT, 32'hffff_ffff, 32'd1, 5'd11, 32'h1, '0);
                add_row("sltu_big", OP_SLTU, 32'hffff_ffff, 32'd1, 5'd12, 32'h0, '0);
                add_row("slt_false", OP_SLT, 32'd5, 32'd3, 5'd13, 32'h0, '0);
                // move-to then move-from on the next cycle
                add_row("mthi", OP_MTHI, 32'h1234_5678, '0, 5'd0, '0, '0);
                add_row("mfhi_moved", OP_MFHI, '0, '0, 5'd14, 32'h1234_5678, '0);
                add_row("mtlo", OP_MTLO, 32'hcafe_f00d, '0, 5'd0, '0, '0);
                add_row("mflo_moved", OP_MFLO, '0, '0, 5'd15, 32'hcafe_f00d, '0);
                // divides, HI holds the remainder and LO the quotient
                add_row("divu_100_7", OP_DIVU, 32'd100, 32'd7, 5'd0, 32'd14, 32'd2);
                add_row("mfhi_div", OP_MFHI, '0, '0, 5'd16, 32'd2, '0);
                add_row("mflo_div", OP_MFLO, '0, '0, 5'd17, 32'd14, '0);
                add_row("div_neg_pos", OP_DIV, 32'hffff_fff9, 32'd2, 5'd0, 32'hffff_fffd,
                        32'hffff_ffff);
                add_row("div_pos_neg", OP_DIV, 32'd7, 32'hffff_fffe, 5'd0, 32'hffff_fffd,
                        32'h1);
                add_row("div_neg_neg", OP_DIV, 32'hffff_fff9, 32'hffff_fffe, 5'd0, 32'd3,
                        32'hffff_ffff);
                add_row("divu_max_16", OP_DIVU, 32'hffff_ffff, 32'h10, 5'd0, 32'h0fff_ffff,
                        32'hf);
                add_row("divu_zero", OP_DIVU, 32'hdead_beef, '0, 5'd0, '0, '0);
                add_row("div_refill", OP_DIV, 32'hffff_fff9, 32'hffff_fffe, 5'd0, 32'd3,
                        32'hffff_ffff);
                add_row("div_zero", OP_DIV, 32'd12345, '0, 5'd0, '0, '0);
                for (int i = 0; i < RAND_ALU_ROWS; i++)
                begin
                        op = alu_ops[int'(next_rand() % 32'd11)];
                        a  = next_rand();
                        b  = next_rand();
                        add_row($sformatf("rand_%s_%0d", op.name(), i), op, a, b,
                                reg_addr_t'(next_rand()), expect_alu_result(op, a, b), '0);
                end
                for (int i = 0; i < RAND_DIV_ROWS; i++)
                begin
                        op = (i % 2 == 1) ? OP_DIV : OP_DIVU;
                        a  = next_rand();
                        b  = next_rand() >> (next_rand() % 32'd28);
                        s  = next_rand();
                        if (op == OP_DIV && s[0])
                                b = -b;
                        expect_div_result(op, a, b, hi, lo);
                        add_row($sformatf("rand_%s_%0d", op.name(), i), op, a, b, 5'd0, lo, hi);
                end
        endfunction

        task automatic issue_row(input row_t r);
                @(posedge clk);
                issue_i  <= 1'b1;
                op_i     <= r.op;
                opnd_a_i <= r.a;
                opnd_b_i <= r.b;
                wd_i     <= r.wd;
        endtask

        task automatic idle_cycle();
                @(posedge clk);
                issue_i <= 1'b0;
                op_i    <= OP_NOP;
        endtask

        // busy rises on the edge after the start strobe
        task automatic wait_not_busy(input string name);
                int cycles;
                cycles = 0;
                @(negedge clk);
                if (!busy_o)
                        checker_inst.note_error($sformatf("%s: divider never went busy", name));
                while (busy_o && cycles < BUSY_TIMEOUT)
                begin
                        @(negedge clk);
                        cycles++;
                end
                if (busy_o)
                        checker_inst.note_error($sformatf("%s: divider still busy after %0d cycles",
                                                          name, BUSY_TIMEOUT));
        endtask

        initial
        begin
                reset_i  = 1'b1;
                issue_i  = 1'b0;
                op_i     = OP_NOP;
                opnd_a_i = '0;
                opnd_b_i = '0;
                wd_i     = '0;
                build_table();
                repeat (2) @(posedge clk);
                reset_i <= 1'b0;
                @(negedge clk);
                checker_inst.check_hilo("reset_hilo", '0, '0);
                checker_inst.check_busy("reset_busy", 1'b0);
                foreach (rows[i])
                begin
                        if (rows[i].op == OP_DIV || rows[i].op == OP_DIVU)
                        begin
                                idle_cycle();
                                checker_inst.wait_results();
                                issue_row(rows[i]);
                                idle_cycle();
                                wait_not_busy(rows[i].name);
                                checker_inst.check_hilo(rows[i].name, rows[i].exp_hi, rows[i].exp);
                        end
                        else
                        begin
                                if (checker_inst.writes_register(rows[i].op))
                                        checker_inst.push_expect(rows[i].name, rows[i].wd,
                                                                 rows[i].exp);
                                issue_row(rows[i]);
                        end
                end
                idle_cycle();
                checker_inst.wait_results();
                $display("tests passed %0d, failed %0d", checker_inst.pass_count,
                         checker_inst.fail_count);
                if (checker_inst.fail_count == 0)
                        $display("RESULT: PASS");
                else
                        $display("RESULT: FAIL");
                $finish;
        end

endmodule

// ==== src.f ====
+incdir+.
ex_pkg.sv
alu_stage.sv
div_unit.sv
hilo_writeback.sv
ex_unit.sv
ex_checker.sv
tb_ex_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module tb_ex_unit -Mdir obj_dir -o sim_tb_ex_unit

./obj_dir/sim_tb_ex_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: PASS" sim.log
then
        echo "simulation passed"
else
        echo "simulation failed"
        exit 1
fi
